// ==== list.f ====
hdl/vdp_bridge_pkg.sv
hdl/cpu_pins_if.sv
hdl/pin_filter.sv
hdl/cpu_bus_capture.sv
hdl/frac_clock_divider.sv
hdl/mcp3202_reader.sv
hdl/audio_lowpass.sv
hdl/vdp_bridge_top.sv
testbench/tb_vdp_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

mkdir -p build
if [ $? -ne 0 ]; then
    echo "cannot create the build directory"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps --top-module tb_vdp_bridge \
    -f list.f --Mdir build/obj_dir -o tb_vdp_bridge
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./build/obj_dir/tb_vdp_bridge > build/sim.log 2>&1
sim_status=$?
cat build/sim.log

if grep -q "Result: FAILED" build/sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

// ==== testbench/tb_vdp_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vdp_bridge;

    localparam int         WAIT_LIMIT   = 400;       // cycles allowed per wait loop
    localparam int         ADC_LIMIT    = 40000;     // eight conversions take ~24000
    localparam int         NUM_CONV     = 8;
    localparam logic [3:0] EXPECTED_CMD = 4'b1101;   // start, sgl, odd, msbf

    logic                      clk_w;
    logic                      reset_n_w;
    logic                      csr_n;
    logic                      csw_n;
    vdp_bridge_pkg::vdp_port_t mode;
    vdp_bridge_pkg::cpu_data_t cd_in;
    vdp_bridge_pkg::cpu_data_t cd_out;
    logic                      cd_oe;
    logic                      vdp_req;
    logic                      vdp_wrt;
    vdp_bridge_pkg::vdp_port_t vdp_adr;
    vdp_bridge_pkg::cpu_data_t vdp_dbo;
    vdp_bridge_pkg::cpu_data_t vdp_dbi;
    logic                      gromclk_ena_n;
    logic                      cpuclk_ena_n;
    logic                      cpuclk;
    logic                      cpuclk_oe;
    logic                      gromclk;
    logic                      adc_clk;
    logic                      adc_cs;
    logic                      adc_mosi;
    logic                      adc_miso = 1'b0;
    vdp_bridge_pkg::sample_t   audio_sample;
    logic                      audio_valid;

    logic [15:0]               bus_lfsr = 16'd80;     // bus stimulus
    logic [15:0]               adc_lfsr = 16'd80;     // adc model data
    int                        req_seen;
    int                        audio_checked = 0;
    logic [31:0]               ref_acc = '0;          // reference filter state
    vdp_bridge_pkg::adc_word_t sent_words[$];         // words sent by the adc model

    // adc model state
    logic                      prev_clk = 1'b0;
    logic                      prev_cs = 1'b1;
    logic                      started = 1'b0;
    int                        cmd_cnt = 0;
    int                        out_idx = -1;
    logic [3:0]                rx_cmd = '0;
    vdp_bridge_pkg::adc_word_t tx_shift = '0;

    vdp_bridge_top vdp_bridge_top_i (
        .clk_w         (clk_w),
        .reset_n_w     (reset_n_w),
        .csr_n         (csr_n),
        .csw_n         (csw_n),
        .mode          (mode),
        .cd_in         (cd_in),
        .cd_out        (cd_out),
        .cd_oe         (cd_oe),
        .vdp_req       (vdp_req),
        .vdp_wrt       (vdp_wrt),
        .vdp_adr       (vdp_adr),
        .vdp_dbo       (vdp_dbo),
        .vdp_dbi       (vdp_dbi),
        .gromclk_ena_n (gromclk_ena_n),
        .cpuclk_ena_n  (cpuclk_ena_n),
        .cpuclk        (cpuclk),
        .cpuclk_oe     (cpuclk_oe),
        .gromclk       (gromclk),
        .adc_clk       (adc_clk),
        .adc_cs        (adc_cs),
        .adc_mosi      (adc_mosi),
        .adc_miso      (adc_miso),
        .audio_sample  (audio_sample),
        .audio_valid   (audio_valid)
    );

    initial begin
        clk_w = 1'b0;
        forever #2 clk_w = ~clk_w;   // 4 ns period
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11
    endfunction

    function automatic logic [15:0] draw_bits(inout logic [15:0] state, input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            v     = {v[14:0], state[0]};
        end
        return v;
    endfunction

    // acc moves by (x - acc) / 2^shift with x the word scaled to 32 bits
    function automatic logic [31:0] lowpass_step(input logic [31:0] acc,
                                                 input vdp_bridge_pkg::adc_word_t word);
        longint x;
        longint diff;
        x    = longint'(word) << 20;
        diff = x - longint'(acc);
        return 32'(longint'(acc) + (diff >>> vdp_bridge_pkg::LPF_SHIFT_DEF));
    endfunction

    function automatic logic clock_level(input int sel);
        return (sel == 0) ? cpuclk : gromclk;
    endfunction

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        stop_with_failure();
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(negedge clk_w);
            if (vdp_req) req_seen++;
        end
    endtask

    task automatic measure_clock(input int sel, output int high_len, output int period_len);
        int guard;
        guard = 0;
        while (clock_level(sel) != 1'b0) begin
            @(negedge clk_w);
            guard++;
            if (guard > WAIT_LIMIT) timeout_fail("clock low phase");
        end
        while (clock_level(sel) != 1'b1) begin
            @(negedge clk_w);
            guard++;
            if (guard > WAIT_LIMIT) timeout_fail("clock rising edge");
        end
        high_len = 0;
        while (clock_level(sel) == 1'b1) begin
            high_len++;
            @(negedge clk_w);
            if (high_len > WAIT_LIMIT) timeout_fail("clock falling edge");
        end
        period_len = high_len;
        while (clock_level(sel) == 1'b0) begin
            period_len++;
            @(negedge clk_w);
            if (period_len > WAIT_LIMIT) timeout_fail("end of clock period");
        end
    endtask

    task automatic bus_write();
        vdp_bridge_pkg::vdp_port_t port;
        vdp_bridge_pkg::cpu_data_t data;
        port  = 2'(draw_bits(bus_lfsr, 2));
        data  = 8'(draw_bits(bus_lfsr, 8));
        mode  = port;
        cd_in = data;
        step_cycles(8);                        // let mode settle through the filter
        req_seen = 0;
        csw_n    = 1'b0;
        step_cycles(20);
        check_equal(req_seen, 1, "requests per write");
        check_equal(32'(vdp_wrt), 1, "write flag");
        check_equal(32'(vdp_adr), 32'(port), "write port");
        check_equal(32'(vdp_dbo), 32'(data), "write data");
        csw_n    = 1'b1;
        req_seen = 0;
        step_cycles(20);
        check_equal(req_seen, 0, "requests after write release");
    endtask

    task automatic bus_read();
        vdp_bridge_pkg::vdp_port_t port;
        vdp_bridge_pkg::cpu_data_t data;
        port    = 2'(draw_bits(bus_lfsr, 2));
        data    = 8'(draw_bits(bus_lfsr, 8));
        mode    = port;
        vdp_dbi = data;
        step_cycles(8);
        req_seen = 0;
        csr_n    = 1'b0;
        step_cycles(1);
        check_equal(32'(cd_oe), 1, "cd_oe during read");
        check_equal(32'(cd_out), 32'(data), "cd_out during read");
        step_cycles(19);
        check_equal(req_seen, 1, "requests per read");
        check_equal(32'(vdp_wrt), 0, "read flag");
        check_equal(32'(vdp_adr), 32'(port), "read port");
        csr_n    = 1'b1;
        req_seen = 0;
        step_cycles(20);
        check_equal(req_seen, 0, "requests after read release");
        check_equal(32'(cd_oe), 0, "cd_oe after read");
    endtask

    task automatic strobe_glitch(input int len);
        req_seen = 0;
        csw_n    = 1'b0;
        step_cycles(len);
        csw_n    = 1'b1;
        step_cycles(20);
        check_equal(req_seen, 0, "requests from a short csw_n pulse");
    endtask

    // ------------------------------------------------------------------------
    // mcp3202 model that samples din on rising sck and shifts dout after falling sck
    // ------------------------------------------------------------------------
    always @(negedge clk_w) begin
        if (reset_n_w) begin
            if (prev_cs && !adc_cs) begin          // frame opens
                started = 1'b0;
                cmd_cnt = 0;
                out_idx = -1;
                rx_cmd  = '0;
            end
            if (!adc_cs && adc_clk && !prev_clk) begin
                if (cmd_cnt < 4 && (started || adc_mosi)) begin
                    started = 1'b1;
                    rx_cmd  = {rx_cmd[2:0], adc_mosi};
                    cmd_cnt++;
                    if (cmd_cnt == 4) begin
                        check_equal(32'(rx_cmd), 32'(EXPECTED_CMD), "adc command bits");
                        tx_shift = 12'(draw_bits(adc_lfsr, 12));
                        sent_words.push_back(tx_shift);
                        out_idx = 0;
                    end
                end
            end
            if (!adc_cs && !adc_clk && prev_clk && out_idx >= 0) begin
                if (out_idx == 0) begin
                    adc_miso = 1'b0;               // null bit
                end else if (out_idx <= 12) begin
                    adc_miso = tx_shift[11];       // msb first
                    tx_shift = {tx_shift[10:0], 1'b0};
                end else begin
                    adc_miso = 1'b0;
                end
                out_idx++;
            end
            prev_clk = adc_clk;
            prev_cs  = adc_cs;
        end
    end

    // audio output against the reference filter
    always @(negedge clk_w) begin
        vdp_bridge_pkg::adc_word_t word;
        if (reset_n_w && audio_valid) begin
            if (sent_words.size() == 0) begin
                $display("audio sample arrived with no conversion sent by the adc model");
                stop_with_failure();
            end
            word    = sent_words.pop_front();
            ref_acc = lowpass_step(ref_acc, word);
            check_equal(32'(audio_sample), 32'(ref_acc[31:16]), "audio sample");
            audio_checked++;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        int wait_cnt;
        int high_len;
        int period_len;
        reset_n_w     = 1'b0;
        csr_n         = 1'b1;
        csw_n         = 1'b1;
        mode          = '0;
        cd_in         = '0;
        vdp_dbi       = '0;
        gromclk_ena_n = 1'b1;
        cpuclk_ena_n  = 1'b1;
        req_seen      = 0;
        repeat (8) @(posedge clk_w);
        @(negedge clk_w);
        reset_n_w = 1'b1;

        @(negedge clk_w);
        check_equal(32'(vdp_req), 0, "vdp_req after reset");
        check_equal(32'(adc_cs), 1, "adc_cs after reset");
        check_equal(32'(audio_valid), 0, "audio_valid after reset");
        check_equal(32'(cpuclk), 0, "cpuclk after reset");
        wait_cnt = 1;
        while (!cpuclk) begin
            @(negedge clk_w);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) timeout_fail("first cpuclk rise");
        end
        check_equal(wait_cnt, vdp_bridge_pkg::CPUCLK_LOW_DEF, "cycles to first cpuclk rise");

        // high half is PERIOD - LOW cycles
        measure_clock(0, high_len, period_len);
        check_equal(high_len, vdp_bridge_pkg::CPUCLK_PERIOD_DEF - vdp_bridge_pkg::CPUCLK_LOW_DEF,
                    "cpuclk high time");
        check_equal(period_len, vdp_bridge_pkg::CPUCLK_PERIOD_DEF, "cpuclk period");
        repeat (2 * vdp_bridge_pkg::CPUCLK_PERIOD_DEF) begin
            @(negedge clk_w);
            check_equal(32'(gromclk), 32'(cpuclk), "gromclk follows cpuclk");
        end
        gromclk_ena_n = 1'b0;
        measure_clock(1, high_len, period_len);
        check_equal(high_len,
                    vdp_bridge_pkg::GROMCLK_PERIOD_DEF - vdp_bridge_pkg::GROMCLK_LOW_DEF,
                    "gromclk high time");
        check_equal(period_len, vdp_bridge_pkg::GROMCLK_PERIOD_DEF, "gromclk period");
        gromclk_ena_n = 1'b1;
        check_equal(32'(cpuclk_oe), 0, "cpuclk_oe while disabled");
        cpuclk_ena_n = 1'b0;
        step_cycles(1);
        check_equal(32'(cpuclk_oe), 1, "cpuclk_oe while enabled");
        cpuclk_ena_n = 1'b1;
        step_cycles(1);
        check_equal(32'(cpuclk_oe), 0, "cpuclk_oe after disable");

        repeat (4) bus_write();
        repeat (3) bus_read();
        strobe_glitch(2);
        strobe_glitch(1);

        wait_cnt = 0;
        while (audio_checked < NUM_CONV) begin
            @(posedge clk_w);
            wait_cnt++;
            if (wait_cnt > ADC_LIMIT) timeout_fail("eight audio samples");
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/vdp_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_bridge_top #(
    parameter int FILTER_LEN     = vdp_bridge_pkg::FILTER_LEN_DEF,
    parameter int CPUCLK_LOW     = vdp_bridge_pkg::CPUCLK_LOW_DEF,
    parameter int CPUCLK_PERIOD  = vdp_bridge_pkg::CPUCLK_PERIOD_DEF,
    parameter int GROMCLK_LOW    = vdp_bridge_pkg::GROMCLK_LOW_DEF,
    parameter int GROMCLK_PERIOD = vdp_bridge_pkg::GROMCLK_PERIOD_DEF,
    parameter int SCK_LOW        = vdp_bridge_pkg::SCK_LOW_DEF,
    parameter int SCK_PERIOD     = vdp_bridge_pkg::SCK_PERIOD_DEF,
    parameter int SGL            = 1,
    parameter int ODD            = 0,
    parameter int LPF_SHIFT      = vdp_bridge_pkg::LPF_SHIFT_DEF
) (
    input  logic                      clk_w,
    input  logic                      reset_n_w,
    // cpu bus
    input  logic                      csr_n,
    input  logic                      csw_n,
    input  vdp_bridge_pkg::vdp_port_t mode,
    input  vdp_bridge_pkg::cpu_data_t cd_in,
    output vdp_bridge_pkg::cpu_data_t cd_out,
    output logic                      cd_oe,
    // vdp side
    output logic                      vdp_req,
    output logic                      vdp_wrt,
    output vdp_bridge_pkg::vdp_port_t vdp_adr,
    output vdp_bridge_pkg::cpu_data_t vdp_dbo,
    input  vdp_bridge_pkg::cpu_data_t vdp_dbi,
    // board clocks
    input  logic                      gromclk_ena_n,
    input  logic                      cpuclk_ena_n,
    output logic                      cpuclk,
    output logic                      cpuclk_oe,
    output logic                      gromclk,
    // audio adc
    output logic                      adc_clk,
    output logic                      adc_cs,
    output logic                      adc_mosi,
    input  logic                      adc_miso,
    output vdp_bridge_pkg::sample_t   audio_sample,
    output logic                      audio_valid
);

    cpu_pins_if pins ();

    logic [3:0]                raw_pins;     // {mode, csw_n, csr_n}
    logic [3:0]                filt_pins;
    logic                      grom_div;
    logic                      sck;
    logic                      sck_rise;
    logic                      sck_fall;
    logic                      adc_sck_en;
    vdp_bridge_pkg::adc_word_t adc_data;
    logic                      adc_valid;

    // --------------------------------------------------------------------------
    // cpu bus
    // --------------------------------------------------------------------------
    assign raw_pins = {mode, csw_n, csr_n};

    for (genvar gi = 0; gi < 4; gi++) begin : g_pin_filter
        pin_filter #(
            .FILTER_LEN (FILTER_LEN)
        ) pin_filter_i (
            .clk_w     (clk_w),
            .reset_n_w (reset_n_w),
            .din       (raw_pins[gi]),
            .dout      (filt_pins[gi])
        );
    end

    assign pins.csr_n = filt_pins[0];
    assign pins.csw_n = filt_pins[1];
    assign pins.mode  = filt_pins[3:2];

    cpu_bus_capture cpu_bus_capture_i (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .pins      (pins),
        .cd_in     (cd_in),
        .vdp_req   (vdp_req),
        .vdp_wrt   (vdp_wrt),
        .vdp_adr   (vdp_adr),
        .vdp_dbo   (vdp_dbo)
    );

    assign cd_oe  = ~csr_n;   // drive the bus straight off the raw strobe
    assign cd_out = vdp_dbi;

    // --------------------------------------------------------------------------
    // clocks
    // --------------------------------------------------------------------------
    frac_clock_divider #(
        .LOW    (CPUCLK_LOW),
        .PERIOD (CPUCLK_PERIOD)
    ) cpuclk_div_i (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .clk_out   (cpuclk),
        .rise      (),
        .fall      ()
    );

    frac_clock_divider #(
        .LOW    (GROMCLK_LOW),
        .PERIOD (GROMCLK_PERIOD)
    ) gromclk_div_i (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .clk_out   (grom_div),
        .rise      (),
        .fall      ()
    );

    assign gromclk   = gromclk_ena_n ? cpuclk : grom_div;
    assign cpuclk_oe = ~cpuclk_ena_n;

    // --------------------------------------------------------------------------
    // audio adc
    // --------------------------------------------------------------------------
    frac_clock_divider #(
        .LOW    (SCK_LOW),
        .PERIOD (SCK_PERIOD)
    ) sck_div_i (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .clk_out   (sck),
        .rise      (sck_rise),
        .fall      (sck_fall)
    );

    mcp3202_reader #(
        .SGL (SGL),
        .ODD (ODD)
    ) mcp3202_reader_i (
        .clk_w      (clk_w),
        .reset_n_w  (reset_n_w),
        .sck_rise   (sck_rise),
        .sck_fall   (sck_fall),
        .adc_miso   (adc_miso),
        .adc_mosi   (adc_mosi),
        .adc_cs     (adc_cs),
        .adc_sck_en (adc_sck_en),
        .adc_data   (adc_data),
        .adc_valid  (adc_valid)
    );

    assign adc_clk = sck & adc_sck_en;   // gated outside a frame

    audio_lowpass #(
        .LPF_SHIFT (LPF_SHIFT)
    ) audio_lowpass_i (
        .clk_w        (clk_w),
        .reset_n_w    (reset_n_w),
        .adc_data     (adc_data),
        .adc_valid    (adc_valid),
        .audio_sample (audio_sample),
        .audio_valid  (audio_valid)
    );

endmodule

`default_nettype wire

// ==== hdl/audio_lowpass.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_lowpass #(
    parameter int LPF_SHIFT = vdp_bridge_pkg::LPF_SHIFT_DEF
) (
    input  logic                      clk_w,
    input  logic                      reset_n_w,
    input  vdp_bridge_pkg::adc_word_t adc_data,
    input  logic                      adc_valid,
    output vdp_bridge_pkg::sample_t   audio_sample,
    output logic                      audio_valid
);

    vdp_bridge_pkg::lpf_acc_t acc_r;
    vdp_bridge_pkg::lpf_acc_t x_in;    // new sample in the accumulator scale
    logic signed [32:0]       diff;    // x minus acc, one bit wider
    logic signed [32:0]       step;

    assign x_in = {adc_data, 4'b0000, 16'h0000};
    assign diff = $signed({1'b0, x_in}) - $signed({1'b0, acc_r});
    assign step = diff >>> LPF_SHIFT;

    // acc += (x - acc) / 2^shift
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            acc_r       <= '0;
            audio_valid <= 1'b0;
        end else begin
            audio_valid <= adc_valid;
            if (adc_valid) begin
                acc_r <= acc_r + vdp_bridge_pkg::lpf_acc_t'(step);
            end
        end
    end

    assign audio_sample = acc_r[31:16];

endmodule

`default_nettype wire

// ==== hdl/mcp3202_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcp3202_reader #(
    parameter int SGL = 1,
    parameter int ODD = 0
) (
    input  logic                      clk_w,
    input  logic                      reset_n_w,
    input  logic                      sck_rise,
    input  logic                      sck_fall,
    input  logic                      adc_miso,
    output logic                      adc_mosi,
    output logic                      adc_cs,
    output logic                      adc_sck_en,
    output vdp_bridge_pkg::adc_word_t adc_data,
    output logic                      adc_valid
);

    // bit counter phases within one frame
    //   0..3   command bits, advanced on sck falls
    //   4      rise where the adc takes msbf
    //   5      null bit
    //   6..17  data bits, msb first
    //   18     wait for the fall that closes the frame
    localparam int CMD_BITS   = 4;
    localparam int DATA_FIRST = 6;
    localparam int FRAME_END  = 18;

    logic [3:0]  cmd;            // start, sgl, odd, msbf
    logic [4:0]  bit_cnt;
    logic [10:0] shift_r;        // data bits gathered so far
    logic        data_bit;

    assign cmd = {1'b1, (SGL != 0), (ODD != 0), 1'b1};

    assign data_bit = !adc_cs && sck_rise &&
                      (bit_cnt >= 5'(DATA_FIRST)) && (bit_cnt < 5'(FRAME_END));

    // --------------------------------------------------------------------------
    // frame sequencing
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            adc_cs     <= 1'b1;
            adc_sck_en <= 1'b0;
            adc_mosi   <= 1'b0;
            bit_cnt    <= '0;
            adc_valid  <= 1'b0;
        end else begin
            adc_valid <= 1'b0;
            if (adc_cs) begin
                if (sck_fall) begin          // open a new frame
                    adc_cs     <= 1'b0;
                    adc_sck_en <= 1'b1;
                    bit_cnt    <= '0;
                end
            end else if (bit_cnt < 5'(CMD_BITS)) begin
                if (sck_fall) begin
                    adc_mosi <= cmd[2'd3 - bit_cnt[1:0]];
                    bit_cnt  <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt < 5'(FRAME_END)) begin
                if (sck_rise) begin
                    adc_mosi <= 1'b0;
                    bit_cnt  <= bit_cnt + 1'b1;
                    if (bit_cnt == 5'(FRAME_END - 1)) begin
                        adc_valid <= 1'b1;   // last bit taken
                    end
                end
            end else if (sck_fall) begin
                adc_cs     <= 1'b1;          // cs high for one sck period
                adc_sck_en <= 1'b0;
            end
        end
    end

    // --------------------------------------------------------------------------
    // data shift
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_w) begin
        if (data_bit) begin
            shift_r <= {shift_r[9:0], adc_miso};
            if (bit_cnt == 5'(FRAME_END - 1)) begin
                adc_data <= {shift_r, adc_miso};
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frac_clock_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module frac_clock_divider #(
    parameter int LOW    = vdp_bridge_pkg::CPUCLK_LOW_DEF,
    parameter int PERIOD = vdp_bridge_pkg::CPUCLK_PERIOD_DEF
) (
    input  logic clk_w,
    input  logic reset_n_w,
    output logic clk_out,
    output logic rise,
    output logic fall
);

    localparam int CNT_W = $clog2(PERIOD);

    logic [CNT_W-1:0] div_cnt;
    logic             at_low;     // end of the low half
    logic             at_end;     // end of the whole period

    assign at_low = (div_cnt == CNT_W'(LOW - 1));
    assign at_end = (div_cnt == CNT_W'(PERIOD - 1));

    // odd periods give halves one cycle apart
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            div_cnt <= '0;
            clk_out <= 1'b0;
            rise    <= 1'b0;
            fall    <= 1'b0;
        end else begin
            div_cnt <= at_end ? '0 : div_cnt + 1'b1;
            rise    <= 1'b0;
            fall    <= 1'b0;
            if (at_low || at_end) begin
                clk_out <= ~clk_out;
                rise    <= ~clk_out;  // going high
                fall    <= clk_out;   // going low
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_bus_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_capture (
    input  logic                      clk_w,
    input  logic                      reset_n_w,
    cpu_pins_if.capture               pins,
    input  vdp_bridge_pkg::cpu_data_t cd_in,
    output logic                      vdp_req,
    output logic                      vdp_wrt,
    output vdp_bridge_pkg::vdp_port_t vdp_adr,
    output vdp_bridge_pkg::cpu_data_t vdp_dbo
);

    vdp_bridge_pkg::bus_state_t state;
    logic [1:0]                 cs_pair;    // {csr_n, csw_n} as seen now
    logic [1:0]                 cs_latch;   // pair at the last capture
    logic                       access;

    assign cs_pair = {pins.csr_n, pins.csw_n};
    assign access  = pins.csr_n ^ pins.csw_n;   // exactly one select low

    // --------------------------------------------------------------------------
    // one request per access
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            state    <= vdp_bridge_pkg::ARMED;
            cs_latch <= 2'b11;
            vdp_req  <= 1'b0;
        end else begin
            case (state)
                vdp_bridge_pkg::ARMED: begin
                    vdp_req  <= access;
                    cs_latch <= cs_pair;
                    state    <= vdp_bridge_pkg::HOLD;
                end
                vdp_bridge_pkg::HOLD: begin
                    vdp_req <= 1'b0;
                    // re-arm only once the selects move
                    if (cs_pair != cs_latch) begin
                        state <= vdp_bridge_pkg::ARMED;
                    end
                end
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // request payload, held until the next access
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_w) begin
        if (state == vdp_bridge_pkg::ARMED && access) begin
            vdp_wrt <= ~pins.csw_n;
            vdp_adr <= pins.mode;
            vdp_dbo <= cd_in;       // cpu keeps data stable under cs
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pin_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pin_filter #(
    parameter int FILTER_LEN = vdp_bridge_pkg::FILTER_LEN_DEF
) (
    input  logic clk_w,
    input  logic reset_n_w,
    input  logic din,
    output logic dout
);

    localparam int CNT_W = $clog2(FILTER_LEN + 1);

    logic [1:0]       sync_r;       // two-flop synchronizer
    logic [CNT_W-1:0] stable_cnt;   // cycles the pin has differed from dout

    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            sync_r     <= 2'b11;
            stable_cnt <= '0;
            dout       <= 1'b1;     // strobes idle high
        end else begin
            sync_r <= {sync_r[0], din};
            if (sync_r[1] == dout) begin
                stable_cnt <= '0;   // glitch ended, start over
            end else if (stable_cnt == CNT_W'(FILTER_LEN - 1)) begin
                stable_cnt <= '0;
                dout       <= sync_r[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_pins_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// filtered cpu strobes and port select
interface cpu_pins_if;

    logic                      csr_n;   // read select, active low
    logic                      csw_n;   // write select, active low
    vdp_bridge_pkg::vdp_port_t mode;    // port number

    modport filter (
        output csr_n,
        output csw_n,
        output mode
    );

    modport capture (
        input  csr_n,
        input  csw_n,
        input  mode
    );

endinterface

`default_nettype wire

// ==== hdl/vdp_bridge_pkg.sv ====
`default_nettype none

package vdp_bridge_pkg;

    // --------------------------------------------------------------------------
    // data types
    // --------------------------------------------------------------------------
    typedef logic [7:0]  cpu_data_t;    // cpu data byte
    typedef logic [1:0]  vdp_port_t;    // vdp port from the mode pins
    typedef logic [11:0] adc_word_t;    // raw mcp3202 conversion
    typedef logic [15:0] sample_t;      // unsigned audio sample
    typedef logic [31:0] lpf_acc_t;     // sample lives in the upper half

    typedef enum logic {
        ARMED,                          // waiting for a chip select
        HOLD                            // access seen, wait for pins to move
    } bus_state_t;

    // --------------------------------------------------------------------------
    // defaults for a 50 MHz system clock
    // --------------------------------------------------------------------------
    localparam int FILTER_LEN_DEF     = 3;     // stable cycles per pin

    localparam int CPUCLK_LOW_DEF     = 6;     // about 3.58 MHz
    localparam int CPUCLK_PERIOD_DEF  = 14;

    localparam int GROMCLK_LOW_DEF    = 55;    // cpu clock over eight
    localparam int GROMCLK_PERIOD_DEF = 112;

    localparam int SCK_LOW_DEF        = 75;    // adc spi clock
    localparam int SCK_PERIOD_DEF     = 150;

    localparam int LPF_SHIFT_DEF      = 4;     // filter pole

endpackage

`default_nettype wire
